/* Makefile */
# Verilator compile, run and clean for the rv_core testbench
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Verification failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash or the fail message in the log both end with a failing status
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "Simulation run unsuccessful, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
source/rv_isa_pkg.sv
source/core_bus_pkg.sv
source/pc_fetch.sv
source/decode_ctrl.sv
source/reg_file.sv
source/alu.sv
source/load_store_unit.sv
source/rv_core.sv
verif/tb_checker.sv
verif/tb_top.sv

/* source/alu.sv */
// ALU with the ten RV32I integer operations and the branch condition compare
`timescale 1ns/1ps

module alu (
    input  rv_isa_pkg::alu_op_t  i_op,
    input  rv_isa_pkg::br_cond_t i_br_cond,
    input  rv_isa_pkg::word_t    i_a,
    input  rv_isa_pkg::word_t    i_b,
    output rv_isa_pkg::word_t    o_result,
    output logic                 o_branch_taken
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;                             // Signed compare
    logic       ltu;                            // Unsigned compare

    assign shamt = i_b[4:0];                    // Upper bits ignored
    assign eq    = (i_a == i_b);
    assign lt    = ($signed(i_a) < $signed(i_b));
    assign ltu   = (i_a < i_b);

    always_comb begin
        case (i_op)
            ADD:     o_result = i_a + i_b;      // Carry out dropped
            SUB:     o_result = i_a - i_b;
            SLL:     o_result = i_a << shamt;
            SLT:     o_result = {{(XLEN-1){1'b0}}, lt};
            SLTU:    o_result = {{(XLEN-1){1'b0}}, ltu};
            XOR:     o_result = i_a ^ i_b;
            SRL:     o_result = i_a >> shamt;
            SRA:     o_result = $signed(i_a) >>> shamt;
            OR:      o_result = i_a | i_b;
            default: o_result = i_a & i_b;
        endcase
    end

    // Branch resolution
    always_comb begin
        case (i_br_cond)
            EQ:      o_branch_taken = eq;
            NE:      o_branch_taken = ~eq;
            LT:      o_branch_taken = lt;
            GE:      o_branch_taken = ~lt;      // Greater or equal
            LTU:     o_branch_taken = ltu;
            GEU:     o_branch_taken = ~ltu;
            default: o_branch_taken = 1'b0;     // NONE
        endcase
    end

endmodule

/* source/core_bus_pkg.sv */
// Core bus package with the control word, Wishbone request and response, and retire record
package core_bus_pkg;

    // Operand A source, zero serves lui and PC serves auipc
    typedef enum logic [1:0] {
        OPA_REG  = 2'd0,
        OPA_ZERO = 2'd1,
        OPA_PC   = 2'd2
    } op_a_sel_t;

    typedef struct packed {
        logic                  reg_wen;
        logic                  alu_src_imm;    // Operand B from immediate
        op_a_sel_t             op_a_sel;
        rv_isa_pkg::alu_op_t   alu_op;
        rv_isa_pkg::br_cond_t  br_cond;
        logic                  mem_read;
        logic                  mem_write;
        rv_isa_pkg::mem_size_t mem_size;
        logic                  mem_unsigned;   // lbu and lhu
        logic                  wb_from_mem;    // Write back the load data
    } ctrl_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        rv_isa_pkg::word_t adr;                // Word aligned
        rv_isa_pkg::word_t dat_w;
        logic [3:0]        sel;                // Byte lanes
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        rv_isa_pkg::word_t dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::word_t     next_pc;
        rv_isa_pkg::word_t     inst;
        rv_isa_pkg::reg_addr_t rd_waddr;       // Zero when nothing is written
        rv_isa_pkg::word_t     rd_wdata;
    } retire_t;

endpackage

/* source/decode_ctrl.sv */
// Instruction decoder producing the control word, the ALU operation and the immediate
`timescale 1ns/1ps

module decode_ctrl (
    input  rv_isa_pkg::word_t   i_inst,
    output core_bus_pkg::ctrl_t o_ctrl,
    output rv_isa_pkg::word_t   o_imm
);
    import rv_isa_pkg::*;
    import core_bus_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_5;                       // sub and sra select
    imm_fmt_t   fmt;

    assign opcode   = opcode_t'(i_inst[6:0]);
    assign funct3   = i_inst[14:12];
    assign funct7_5 = i_inst[30];

    // ALU operation of OP and OP_IMM
    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub_en,
                                           input logic arith);
        case (f3)
            F3_ADD:  return sub_en ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return arith ? SRA : SRL;
            F3_OR:   return OR;
            default: return AND;
        endcase
    endfunction

    function automatic br_cond_t br_decode(input logic [2:0] f3);
        case (f3)
            F3_BEQ:  return EQ;
            F3_BNE:  return NE;
            F3_BLT:  return LT;
            F3_BGE:  return GE;
            F3_BLTU: return LTU;
            F3_BGEU: return GEU;
            default: return NONE;               // 010 and 011 are not branches
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Main control
    always_comb begin
        o_ctrl         = '0;                    // Unknown opcode retires with no effect
        o_ctrl.br_cond = NONE;
        fmt            = IMM_NONE;
        case (opcode)
            OP: begin
                o_ctrl.reg_wen = 1'b1;
                o_ctrl.alu_op  = alu_decode(funct3, funct7_5, funct7_5);
            end
            OP_IMM: begin
                o_ctrl.reg_wen     = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = alu_decode(funct3, 1'b0, funct7_5); // No subi
                fmt                = IMM_I;
            end
            LOAD: begin
                o_ctrl.reg_wen      = 1'b1;
                o_ctrl.alu_src_imm  = 1'b1;     // Address is rs1 + imm
                o_ctrl.mem_read     = 1'b1;
                o_ctrl.mem_size     = mem_size_t'(funct3[1:0]);
                o_ctrl.mem_unsigned = funct3[2];
                o_ctrl.wb_from_mem  = 1'b1;
                fmt                 = IMM_I;
            end
            STORE: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.mem_size    = mem_size_t'(funct3[1:0]);
                fmt                = IMM_S;
            end
            BRANCH: begin
                o_ctrl.br_cond = br_decode(funct3);  // ALU compares rs1 and rs2
                fmt            = IMM_B;
            end
            LUI: begin
                o_ctrl.reg_wen     = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.op_a_sel    = OPA_ZERO;  // 0 + upper imm
                fmt                = IMM_U;
            end
            AUIPC: begin
                o_ctrl.reg_wen     = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.op_a_sel    = OPA_PC;    // PC + upper imm
                fmt                = IMM_U;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediate generation, sign bit is always inst[31]
    always_comb begin
        case (fmt)
            IMM_I:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            IMM_S:   o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            IMM_B:   o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                              i_inst[11:8], 1'b0};
            IMM_U:   o_imm = {i_inst[31:12], 12'd0};
            default: o_imm = '0;
        endcase
    end

endmodule

/* source/load_store_unit.sv */
// Load/store unit as a Wishbone classic master with lane select, store shift and load extend
`timescale 1ns/1ps

module load_store_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_bus_pkg::ctrl_t   i_ctrl,
    input  rv_isa_pkg::word_t     i_addr,       // ALU result, rs1 + imm
    input  rv_isa_pkg::word_t     i_store_data, // rs2
    input  core_bus_pkg::wb_rsp_t i_dmem,
    output core_bus_pkg::wb_req_t o_dmem,
    output rv_isa_pkg::word_t     o_load_data,
    output logic                  o_stall
);
    import rv_isa_pkg::*;

    logic       mem_req;                        // Load or store in decode
    logic       done_q;                         // Ack taken last cycle
    logic [1:0] offset;                         // Byte within the word
    logic [3:0] lane_mask;
    word_t      rd_shifted;

    assign mem_req = i_ctrl.mem_read | i_ctrl.mem_write;
    assign offset  = i_addr[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Request side
    always_comb begin
        case (i_ctrl.mem_size)
            MEM_B:   lane_mask = 4'b0001 << offset;
            MEM_H:   lane_mask = 4'b0011 << offset; // Aligned halves only
            default: lane_mask = 4'b1111;
        endcase
    end

    // Fields stay steady while waiting because the PC and registers are held
    always_comb begin
        o_dmem.cyc   = mem_req & ~done_q;
        o_dmem.stb   = mem_req & ~done_q;
        o_dmem.we    = i_ctrl.mem_write;
        o_dmem.adr   = {i_addr[XLEN-1:2], 2'b00};
        o_dmem.dat_w = i_store_data << {offset, 3'b000}; // Move into its lanes
        o_dmem.sel   = lane_mask;
    end

    // One idle cycle after every ack, and no request during reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b1;
        end else begin
            done_q <= o_dmem.stb & i_dmem.ack;
        end
    end

    assign o_stall = done_q | (mem_req & ~i_dmem.ack);

    ////////////////////////////////////////////////////////////////////////////
    // Load alignment and extension
    assign rd_shifted = i_dmem.dat_r >> {offset, 3'b000};

    always_comb begin
        case (i_ctrl.mem_size)
            MEM_B: begin
                o_load_data = i_ctrl.mem_unsigned ? {24'd0, rd_shifted[7:0]}
                                                  : {{24{rd_shifted[7]}}, rd_shifted[7:0]};
            end
            MEM_H: begin
                o_load_data = i_ctrl.mem_unsigned ? {16'd0, rd_shifted[15:0]}
                                                  : {{16{rd_shifted[15]}}, rd_shifted[15:0]};
            end
            default: o_load_data = rd_shifted;  // lw, offset is zero
        endcase
    end

    // stb comes with cyc, and every access is aligned to its size
    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        o_dmem.stb |-> o_dmem.cyc &&
                       (i_ctrl.mem_size != MEM_H || offset[0] == 1'b0) &&
                       (i_ctrl.mem_size != MEM_W || offset == 2'b00));

    // Pending request held unchanged until ack
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        o_dmem.stb && !i_dmem.ack |=> o_dmem.stb && $stable(o_dmem));

endmodule

/* source/pc_fetch.sv */
// Program counter with branch target and next-PC selection, drives the fetch address
`timescale 1ns/1ps

module pc_fetch #(
    parameter rv_isa_pkg::word_t RESET_ADDR = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_stall,          // Memory access not finished
    input  logic              i_branch_taken,
    input  rv_isa_pkg::word_t i_imm,            // B format offset
    output rv_isa_pkg::word_t o_pc,
    output rv_isa_pkg::word_t o_next_pc
);
    import rv_isa_pkg::*;

    word_t pc_q;
    word_t pc_plus4;
    word_t pc_target;

    assign pc_plus4  = pc_q + word_t'(4);
    assign pc_target = pc_q + i_imm;            // imm bit 0 is always zero
    assign o_next_pc = i_branch_taken ? pc_target : pc_plus4;
    assign o_pc      = pc_q;                    // Fetch address as well

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_ADDR;
        end else if (!i_stall) begin
            pc_q <= o_next_pc;                  // Held while a load or store waits
        end
    end

    // Start address and every taken branch offset keep fetch word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00);

endmodule

/* source/reg_file.sv */
// Register file of 32 x 32 bits with two combinational reads, one write and x0 tied to zero
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t i_rs1_addr,
    input  rv_isa_pkg::reg_addr_t i_rs2_addr,
    input  rv_isa_pkg::reg_addr_t i_rd_addr,
    input  logic                  i_wen,        // Already gated by the stall
    input  rv_isa_pkg::word_t     i_wdata,
    output rv_isa_pkg::word_t     o_rs1_data,
    output rv_isa_pkg::word_t     o_rs2_data
);
    import rv_isa_pkg::*;

    word_t regs [1:31];                         // No storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_wdata;         // Writes to x0 dropped
        end
    end

    // No bypass, a write shows up on the read ports after the edge
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* source/rv_core.sv */
// Single-cycle RV32I core top level with fetch, decode, register file, ALU and data port
`timescale 1ns/1ps

module rv_core #(
    parameter rv_isa_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output rv_isa_pkg::word_t     o_imem_addr,
    input  rv_isa_pkg::word_t     i_imem_data,  // Same cycle as the address
    output core_bus_pkg::wb_req_t o_dmem,
    input  core_bus_pkg::wb_rsp_t i_dmem,
    output core_bus_pkg::retire_t o_retire
);
    import rv_isa_pkg::*;
    import core_bus_pkg::*;

    ctrl_t ctrl;
    word_t pc;
    word_t next_pc;
    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t op_a;
    word_t op_b;
    word_t alu_result;
    word_t load_data;
    word_t wb_data;
    logic  branch_taken;
    logic  stall;
    logic  rd_wen;

    pc_fetch #(.RESET_ADDR(RESET_ADDR)) u_pc_fetch (
        .clk(clk), .rst_n(rst_n), .i_stall(stall), .i_branch_taken(branch_taken),
        .i_imm(imm), .o_pc(pc), .o_next_pc(next_pc)
    );

    decode_ctrl u_decode_ctrl (.i_inst(i_imem_data), .o_ctrl(ctrl), .o_imm(imm));

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_addr(i_imem_data[19:15]), .i_rs2_addr(i_imem_data[24:20]),
        .i_rd_addr(i_imem_data[11:7]), .i_wen(rd_wen), .i_wdata(wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    alu u_alu (
        .i_op(ctrl.alu_op), .i_br_cond(ctrl.br_cond), .i_a(op_a), .i_b(op_b),
        .o_result(alu_result), .o_branch_taken(branch_taken)
    );

    load_store_unit u_lsu (
        .clk(clk), .rst_n(rst_n), .i_ctrl(ctrl), .i_addr(alu_result),
        .i_store_data(rs2_data), .i_dmem(i_dmem), .o_dmem(o_dmem),
        .o_load_data(load_data), .o_stall(stall)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand and write-back selects
    always_comb begin
        case (ctrl.op_a_sel)
            OPA_ZERO: op_a = '0;                // lui
            OPA_PC:   op_a = pc;                // auipc
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b        = ctrl.alu_src_imm ? imm : rs2_data;
    assign wb_data     = ctrl.wb_from_mem ? load_data : alu_result;
    assign rd_wen      = ctrl.reg_wen & ~stall; // Write lands on the ack edge
    assign o_imem_addr = pc;

    // Retire report, valid only in the cycle the instruction completes
    always_comb begin
        o_retire.valid    = ~stall;
        o_retire.pc       = pc;
        o_retire.next_pc  = next_pc;
        o_retire.inst     = i_imem_data;
        o_retire.rd_waddr = ctrl.reg_wen ? i_imem_data[11:7] : '0;
        o_retire.rd_wdata = ctrl.reg_wen ? wb_data : '0;
    end

endmodule

/* source/rv_isa_pkg.sv */
// RV32I ISA package with the opcode, funct3, ALU operation and immediate format encodings
package rv_isa_pkg;

    localparam int XLEN = 32;                   // Integer register width

    typedef logic [XLEN-1:0] word_t;            // Data or address word
    typedef logic [4:0]      reg_addr_t;        // x0..x31

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b011_0011,                   // R type ALU
        OP_IMM = 7'b001_0011,                   // I type ALU
        LOAD   = 7'b000_0011,
        STORE  = 7'b010_0011,
        BRANCH = 7'b110_0011,
        LUI    = 7'b011_0111,
        AUIPC  = 7'b001_0111
    } opcode_t;

    // funct3 of OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;    // add, addi, sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // srl or sra by funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [2:0] {
        EQ, NE, LT, GE, LTU, GEU, NONE         // NONE for every non-branch
    } br_cond_t;

    // Access width, funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_B = 2'b00,
        MEM_H = 2'b01,
        MEM_W = 2'b10
    } mem_size_t;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_NONE   // R type carries no immediate
    } imm_fmt_t;

endpackage

/* verif/program_input.hex */
// Words @0: program, one instruction per line; word @40: number of expected records
// Then per record: pc next_pc rd_waddr rd_wdata (rd_wdata ignored when rd_waddr is 0)
@0
800000B7 // lui   x1, 0x80000
FF000113 // addi  x2, x0, -16
00500193 // addi  x3, x0, 5
00310233 // add   x4, x2, x3
402182B3 // sub   x5, x3, x2
00319333 // sll   x6, x3, x3
003123B3 // slt   x7, x2, x3
00313433 // sltu  x8, x2, x3
003144B3 // xor   x9, x2, x3
00315533 // srl   x10, x2, x3
403155B3 // sra   x11, x2, x3
0030E633 // or    x12, x1, x3
003176B3 // and   x13, x2, x3
00001717 // auipc x14, 0x1
10C02023 // sw    x12, 0x100(x0)
102002A3 // sb    x2, 0x105(x0)
10201323 // sh    x2, 0x106(x0)
10500783 // lb    x15, 0x105(x0)
10504803 // lbu   x16, 0x105(x0)
10201883 // lh    x17, 0x102(x0)
10605903 // lhu   x18, 0x106(x0)
10002983 // lw    x19, 0x100(x0)
00718013 // addi  x0, x3, 7
00300A33 // add   x20, x0, x3
00318463 // beq   x3, x3, +8   taken
00100A93 // addi  x21, x0, 1   skipped
00218463 // beq   x3, x2, +8   not taken
00219463 // bne   x3, x2, +8   taken
00100A93 // skipped
00319463 // bne   x3, x3, +8   not taken
00314463 // blt   x2, x3, +8   taken
00100A93 // skipped
0021C463 // blt   x3, x2, +8   not taken
0021D463 // bge   x3, x2, +8   taken
00100A93 // skipped
00315463 // bge   x2, x3, +8   not taken
0021E463 // bltu  x3, x2, +8   taken
00100A93 // skipped
00316463 // bltu  x2, x3, +8   not taken
00317463 // bgeu  x2, x3, +8   taken
00100A93 // skipped
0021F463 // bgeu  x3, x2, +8   not taken
001A8A93 // addi  x21, x21, 1
@40
00000025
00000000 00000004 00000001 80000000
00000004 00000008 00000002 FFFFFFF0
00000008 0000000C 00000003 00000005
0000000C 00000010 00000004 FFFFFFF5
00000010 00000014 00000005 00000015
00000014 00000018 00000006 000000A0
00000018 0000001C 00000007 00000001
0000001C 00000020 00000008 00000000
00000020 00000024 00000009 FFFFFFF5
00000024 00000028 0000000A 07FFFFFF
00000028 0000002C 0000000B FFFFFFFF
0000002C 00000030 0000000C 80000005
00000030 00000034 0000000D 00000000
00000034 00000038 0000000E 00001034
00000038 0000003C 00000000 00000000
0000003C 00000040 00000000 00000000
00000040 00000044 00000000 00000000
00000044 00000048 0000000F FFFFFFF0
00000048 0000004C 00000010 000000F0
0000004C 00000050 00000011 FFFF8000
00000050 00000054 00000012 0000FFF0
00000054 00000058 00000013 80000005
00000058 0000005C 00000000 00000000
0000005C 00000060 00000014 00000005
00000060 00000068 00000000 00000000
00000068 0000006C 00000000 00000000
0000006C 00000074 00000000 00000000
00000074 00000078 00000000 00000000
00000078 00000080 00000000 00000000
00000080 00000084 00000000 00000000
00000084 0000008C 00000000 00000000
0000008C 00000090 00000000 00000000
00000090 00000098 00000000 00000000
00000098 0000009C 00000000 00000000
0000009C 000000A4 00000000 00000000
000000A4 000000A8 00000000 00000000
000000A8 000000AC 00000015 00000001

/* verif/tb_checker.sv */
// Retire checker comparing every retired instruction in order with the expected records
`timescale 1ns/1ps

module tb_checker #(
    parameter int STIM_WORDS     = 256,
    parameter int COUNT_IDX      = 64,          // Count word, records follow it
    parameter int RETIRE_TIMEOUT = 32,          // Cycles per record
    parameter int RESET_TIMEOUT  = 100
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_bus_pkg::retire_t i_retire,
    input  core_bus_pkg::wb_req_t i_dmem_req,
    input  core_bus_pkg::wb_rsp_t i_dmem_rsp,
    input  rv_isa_pkg::word_t     i_stim [0:STIM_WORDS-1],
    output logic                  o_done,
    output int                    o_errors
);
    import rv_isa_pkg::*;

    int mismatches    = 0;
    int timeouts      = 0;
    int bus_errs      = 0;                      // Retire during a pending access
    int setup_errs    = 0;

    task automatic compare_word(input int rec, input string field, input word_t got,
                                input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: record %0d %s is %08h, expected %08h",
                     $time, rec, field, got, exp);
        end
    endtask

    // Sample at each rising edge until a valid retire or the limit
    task automatic wait_retire(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < RETIRE_TIMEOUT) begin
            @(posedge clk);
            seen = i_retire.valid;
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // In-order record compare
    initial begin
        int count;
        int base;
        int n;
        int pc_idx;                             // Program word at the expected pc
        bit seen;
        o_done   = 1'b0;
        o_errors = 0;
        n        = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        count = int'(i_stim[COUNT_IDX]);
        if (rst_n !== 1'b1) begin
            $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
            setup_errs++;
        end else if (count <= 0 || COUNT_IDX + 1 + 4 * count > STIM_WORDS) begin
            $display("ERROR: expected record count %0d is out of range", count);
            setup_errs++;
        end else begin
            for (int rec = 0; rec < count && timeouts == 0; rec++) begin
                base   = COUNT_IDX + 1 + 4 * rec;
                pc_idx = int'(i_stim[base][7:2]);   // ROM holds words 0..63
                wait_retire(seen);
                if (!seen) begin
                    $display("ERROR: record %0d did not retire within %0d cycles",
                             rec, RETIRE_TIMEOUT);
                    timeouts++;
                end else begin
                    compare_word(rec, "pc", i_retire.pc, i_stim[base]);
                    compare_word(rec, "next_pc", i_retire.next_pc, i_stim[base + 1]);
                    compare_word(rec, "inst", i_retire.inst, i_stim[pc_idx]);
                    compare_word(rec, "rd_waddr", word_t'(i_retire.rd_waddr), i_stim[base + 2]);
                    if (i_stim[base + 2] != '0) begin  // Data of x0 carries no meaning
                        compare_word(rec, "rd_wdata", i_retire.rd_wdata, i_stim[base + 3]);
                    end
                end
            end
        end
        o_errors = mismatches + timeouts + bus_errs + setup_errs;
        $display("Checker summary: %0d mismatches, %0d timeouts, %0d bus errors, %0d setup errors",
                 mismatches, timeouts, bus_errs, setup_errs);
        o_done = 1'b1;
    end

    // Nothing may retire while a load or store waits for ack
    always @(posedge clk) begin
        if (rst_n && i_retire.valid && i_dmem_req.stb && !i_dmem_rsp.ack) begin
            bus_errs++;
            $display("ERROR: instruction at pc %08h retired at %0t while a data access waited",
                     i_retire.pc, $time);
        end
    end

endmodule

/* verif/tb_top.sv */
// Testbench top with clock, reset, instruction ROM, Wishbone data RAM and the core under test
`timescale 1ns/1ps

module tb_top;
    import rv_isa_pkg::*;
    import core_bus_pkg::*;

    localparam word_t START_ADDR   = 32'h0000_0000;
    localparam int    STIM_WORDS   = 256;
    localparam int    COUNT_IDX    = 64;        // Program in words 0..63
    localparam int    DONE_TIMEOUT = 10000;     // Cycles
    localparam word_t NOP_INST     = 32'h0000_0013; // addi x0, x0, 0

    logic    clk;
    logic    rst_n;
    word_t   imem_addr;
    word_t   imem_data;
    wb_req_t dmem_req;
    wb_rsp_t dmem_rsp;
    retire_t retire;
    word_t   stim [0:STIM_WORDS-1];         // Program, count and expected records
    word_t   ram [0:255];                   // Data RAM, 1 KiB
    integer  seed;
    int      wait_cnt;                      // Cycles left until ack
    logic    chk_done;
    int      chk_errors;
    int      cycles;

    // Background content, distinct for every word address
    function automatic word_t fill_word(input logic [7:0] a);
        return {a, ~a, 8'hd5, a ^ 8'h3c};
    endfunction

    // Write the selected lanes, return the word and raise ack
    task automatic serve_access();
        int idx;
        idx = int'(dmem_req.adr[9:2]);
        if (dmem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.sel[b]) begin
                    ram[idx][8*b +: 8] = dmem_req.dat_w[8*b +: 8];
                end
            end
        end
        dmem_rsp.dat_r = ram[idx];
        dmem_rsp.ack   = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, reset and end of run
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i] = NOP_INST;                 // Unused program slots run as nop
        end
        $readmemh("verif/program_input.hex", stim);
        repeat (16) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!chk_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (chk_done && chk_errors == 0) begin
            $display("Verification passed");
        end else begin
            if (!chk_done) begin
                $display("ERROR: checker did not finish within %0d cycles", DONE_TIMEOUT);
            end
            $display("Verification failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory models
    assign imem_data = (imem_addr[31:8] == '0) ? stim[imem_addr[7:2]] : NOP_INST;

    // Wishbone slave, driven on the falling edge, ack after 1 to 4 cycles
    initial begin
        seed     = 32'h78017c4e;
        dmem_rsp = '0;
        wait_cnt = 0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = fill_word(i[7:0]);
        end
        forever begin
            @(negedge clk);
            if (!rst_n || dmem_rsp.ack) begin
                dmem_rsp.ack = 1'b0;            // Ack lasts one cycle
                wait_cnt     = 0;
            end else if (dmem_req.cyc && dmem_req.stb) begin
                if (wait_cnt == 0) begin
                    wait_cnt = 1 + int'($unsigned($random(seed)) % 4); // New request
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    serve_access();
                end
            end
        end
    end

    rv_core #(.RESET_ADDR(START_ADDR)) dut (
        .clk(clk), .rst_n(rst_n), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem(dmem_req), .i_dmem(dmem_rsp), .o_retire(retire)
    );

    tb_checker #(.STIM_WORDS(STIM_WORDS), .COUNT_IDX(COUNT_IDX)) u_checker (
        .clk(clk), .rst_n(rst_n), .i_retire(retire), .i_dmem_req(dmem_req),
        .i_dmem_rsp(dmem_rsp), .i_stim(stim), .o_done(chk_done), .o_errors(chk_errors)
    );

endmodule
